//--- logic/int_pipe_pkg.sv
// Integer pipeline shared types

package int_pipe_pkg;

    localparam int XLEN       = 32; // Data path width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by the pipeline
    // Any other value in instr[6:0] is unsupported
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // R-type ALU
        OPC_OP_IMM = 7'b0010011, // I-type ALU
        OPC_LUI    = 7'b0110111  // Load upper immediate
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_PASS_B = 4'b0000, // Second operand through, used by LUI
        ALU_ADD    = 4'b0010,
        ALU_SUB    = 4'b0011,
        ALU_SLL    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SRA    = 4'b0111, // Arithmetic, sign bit replicated
        ALU_SLT    = 4'b1000, // Signed compare
        ALU_SLTU   = 4'b1001, // Unsigned compare
        ALU_AND    = 4'b1010,
        ALU_OR     = 4'b1011,
        ALU_XOR    = 4'b1100
    } alu_op_e;

    // funct3 values shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

//--- logic/decode_stage.sv
// Instruction decode and operand forwarding

module decode_stage import int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     alu_result,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      x_valid,
    output alu_op_e   x_op,
    output word_t     x_a,
    output word_t     x_b,
    output reg_addr_t x_rd
);

    opcode_e   opcode;
    reg_addr_t rd;
    logic [2:0] funct3;
    logic      alt;      // funct7 bit 30
    word_t     imm_i;
    word_t     imm_u;
    word_t     shamt;
    word_t     rs1_fwd;
    word_t     rs2_fwd;
    logic      dec_ok;
    alu_op_e   dec_op;
    word_t     dec_b;

    // Mirror of the execute output register, covers distance two
    logic      m_valid;
    reg_addr_t m_rd;
    word_t     m_data;

    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic sel_alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sel_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign alt      = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign shamt = {27'b0, instr[24:20]};

    // Youngest producer wins
    assign rs1_fwd = (x_valid && x_rd == rs1_addr)   ? alu_result :
                     (m_valid && m_rd == rs1_addr)   ? m_data :
                     (wb_valid && wb_rd == rs1_addr) ? wb_data : rs1_data;
    assign rs2_fwd = (x_valid && x_rd == rs2_addr)   ? alu_result :
                     (m_valid && m_rd == rs2_addr)   ? m_data :
                     (wb_valid && wb_rd == rs2_addr) ? wb_data : rs2_data;

    always_comb begin
        dec_ok = 1'b0;
        dec_op = ALU_PASS_B;
        dec_b  = rs2_fwd;
        case (opcode)
            OPC_OP: begin
                dec_ok = 1'b1;
                dec_op = funct_op(funct3, alt);
            end
            OPC_OP_IMM: begin
                dec_ok = 1'b1;
                dec_op = funct_op(funct3, alt && funct3 == F3_SR); // ADDI has no SUB form
                dec_b  = (funct3 == F3_SLL || funct3 == F3_SR) ? shamt : imm_i;
            end
            OPC_LUI: begin
                dec_ok = 1'b1;
                dec_b  = imm_u;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            x_valid <= instr_valid && dec_ok && rd != '0; // Writes to x0 are dropped here
            m_valid <= x_valid;
        end
    end

    always_ff @(posedge clk) begin
        x_op   <= dec_op;
        x_a    <= rs1_fwd;
        x_b    <= dec_b;
        x_rd   <= rd;
        m_rd   <= x_rd;
        m_data <= alu_result;
    end

    a_x_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        x_valid |-> x_rd != '0);

endmodule

//--- logic/execute_stage.sv
// ALU and execute output register

module execute_stage import int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      x_valid,
    input  alu_op_e   x_op,
    input  word_t     x_a,
    input  word_t     x_b,
    input  reg_addr_t x_rd,
    output word_t     alu_result,
    output logic      r_valid,
    output reg_addr_t r_rd,
    output word_t     r_data
);

    logic [4:0] sh;   // Shift amount, low five bits of B
    logic       lt_s;
    logic       lt_u;

    assign sh   = x_b[4:0];
    assign lt_s = $signed(x_a) < $signed(x_b);
    assign lt_u = x_a < x_b;

    always_comb begin
        case (x_op)
            ALU_PASS_B: alu_result = x_b;
            ALU_ADD:    alu_result = x_a + x_b;
            ALU_SUB:    alu_result = x_a - x_b;
            ALU_SLL:    alu_result = x_a << sh;
            ALU_SRL:    alu_result = x_a >> sh;
            ALU_SRA:    alu_result = word_t'($signed(x_a) >>> sh);
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_AND:    alu_result = x_a & x_b;
            ALU_OR:     alu_result = x_a | x_b;
            ALU_XOR:    alu_result = x_a ^ x_b;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= x_valid;
        end
    end

    // Destination and data follow the valid bit
    always_ff @(posedge clk) begin
        r_rd   <= x_rd;
        r_data <= alu_result;
    end

    // Decode must never hand over an encoding the ALU lacks
    a_op_defined: assert property (@(posedge clk) disable iff (reset)
        x_valid |-> x_op inside {ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
                                 ALU_SRA, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
                                 ALU_XOR});

endmodule

//--- logic/result_stage.sv
// Write-back register and register file

module result_stage import int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      r_valid,
    input  reg_addr_t r_rd,
    input  word_t     r_data,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= r_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= r_rd;
        wb_data <= r_data;
    end

    // Entry is written the cycle after write-back shows it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Decode filters x0 destinations two stages earlier
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_rd != '0);

endmodule

//--- logic/int_pipe.sv
// Three-stage integer pipeline

module int_pipe import int_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      x_valid;
    alu_op_e   x_op;
    word_t     x_a;
    word_t     x_b;
    reg_addr_t x_rd;
    word_t     alu_result; // Also the first forwarding source

    logic      r_valid;
    reg_addr_t r_rd;
    word_t     r_data;

    decode_stage decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .x_valid     (x_valid),
        .x_op        (x_op),
        .x_a         (x_a),
        .x_b         (x_b),
        .x_rd        (x_rd)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .reset      (reset),
        .x_valid    (x_valid),
        .x_op       (x_op),
        .x_a        (x_a),
        .x_b        (x_b),
        .x_rd       (x_rd),
        .alu_result (alu_result),
        .r_valid    (r_valid),
        .r_rd       (r_rd),
        .r_data     (r_data)
    );

    result_stage result_stage_i (
        .clk      (clk),
        .reset    (reset),
        .r_valid  (r_valid),
        .r_rd     (r_rd),
        .r_data   (r_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

//--- testbench/int_pipe_tb.sv
// Integer pipeline testbench

module int_pipe_tb import int_pipe_pkg::*; ();

    localparam int CLK_PERIOD    = 10;
    localparam int N_ZERO        = 31;  // ADDI reads after reset
    localparam int N_CONST       = 16;  // LUI plus ADDI each
    localparam int N_RTYPE       = 200;
    localparam int N_ITYPE       = 200;
    localparam int CHAIN_LEN     = 12;  // Per forwarding distance
    localparam int N_NOWB        = 12;  // Each followed by a read back
    localparam int TOTAL_INSTR   = N_ZERO + 2 * N_CONST + N_RTYPE + N_ITYPE
                                   + 3 * CHAIN_LEN + 2 * N_NOWB;
    localparam int WATCHDOG_TIME = (TOTAL_INSTR + 50) * CLK_PERIOD;

    typedef word_t reg_file_t [32];
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    reg_file_t model;       // Architectural state in issue order
    wb_t       exp_q [$];   // Write-backs still to come
    wb_t       exp_wb;
    integer    seed;
    int        errors;      // Main process
    int        cmp_errors;  // Comparing process
    int        err_mark;
    int        passed;
    int        failed;

    int_pipe int_pipe_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // ISA arithmetic by funct3, alt is instruction bit 30
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t fill;
        fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0; // Sign bits for SRA
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? (a >> b[4:0]) | fill : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Returns 1 when the instruction writes a register
    function automatic logic ref_exec(input word_t ins, input reg_file_t m,
                                      output reg_addr_t rd, output word_t val);
        word_t      a;
        word_t      imm;
        logic [2:0] f3;
        logic       wr;
        a   = m[ins[19:15]];
        imm = {{20{ins[31]}}, ins[31:20]};
        f3  = ins[14:12];
        rd  = ins[11:7];
        val = 32'h0;
        wr  = 1'b1;
        case (ins[6:0])
            7'b0110111: val = {ins[31:12], 12'h000};
            7'b0110011: val = alu_ref(f3, ins[30], a, m[ins[24:20]]);
            7'b0010011: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    val = alu_ref(f3, ins[30], a, {27'b0, ins[24:20]});
                else
                    val = alu_ref(f3, 1'b0, a, imm);  // ADDI never subtracts
            end
            default: wr = 1'b0;
        endcase
        if (rd == 5'd0)
            wr = 1'b0;
        return wr;
    endfunction

    task automatic issue_instr(input word_t ins);
        reg_addr_t rd;
        word_t     val;
        logic      wr;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = ins;
        wr = ref_exec(ins, model, rd, val);
        if (wr) begin
            model[rd] = val;
            exp_q.push_back({rd, val});
        end
    endtask

    // Stop issuing, let the pipeline drain, then score the test
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Test %s ended with %0d expected write-backs that never came",
                     name, exp_q.size());
            errors++;
        end
        if (errors + cmp_errors == err_mark) begin
            passed++;
            $display("Test %s: PASS", name);
        end else begin
            failed++;
            $display("Test %s: FAIL with %0d errors", name, errors + cmp_errors - err_mark);
        end
        err_mark = errors + cmp_errors;
    endtask

    // Compare every write-back pulse against the model queue
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("Time %0t: write-back to x%0d with no instruction expecting one",
                         $time, wb_rd);
                cmp_errors++;
            end else begin
                exp_wb = exp_q.pop_front();
                if (wb_rd != exp_wb.rd) begin
                    $display("ERROR time %0t: wb_rd expected %0d got %0d",
                             $time, exp_wb.rd, wb_rd);
                    cmp_errors++;
                end
                if (wb_data != exp_wb.data) begin
                    $display("ERROR time %0t: wb_data expected %h got %h",
                             $time, exp_wb.data, wb_data);
                    cmp_errors++;
                end
            end
        end
    end

    initial begin
        word_t       ins;
        word_t       rnd;
        word_t       c;
        reg_addr_t   rd;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        word_t       consts [8];
        logic [6:0]  bad_ops [6];

        seed        = 32'h23b3;
        errors      = 0;
        cmp_errors  = 0;
        err_mark    = 0;
        passed      = 0;
        failed      = 0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        for (int i = 0; i < 32; i++)
            model[i] = 32'h0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle pipeline, then every register reads zero
        repeat (3) begin
            @(negedge clk);
            if (wb_valid) begin
                $display("wb_valid went high after reset with no instruction issued");
                errors++;
            end
        end
        // Each result lands in a register that was already read
        for (int j = 1; j <= N_ZERO; j++)
            issue_instr(enc_i(12'h000, reg_addr_t'(j), F3_ADD, reg_addr_t'(j > 1 ? j - 1 : j)));
        finish_test("reset state");

        consts = '{32'h1234_5678, 32'hdead_beef, 32'h0000_0800, 32'hffff_f800,
                   32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001};
        for (int k = 0; k < N_CONST; k++) begin
            if (k < 8)
                c = consts[k];
            else
                c = rand_word();
            rd  = reg_addr_t'(k + 1);
            rnd = c + 32'h800;  // Upper part absorbs a negative low half
            issue_instr(enc_u(rnd[31:12], rd));
            issue_instr(enc_i(c[11:0], rd, F3_ADD, rd));
            if (model[rd] != c) begin
                $display("Constant %h was not rebuilt by LUI and ADDI in the model", c);
                errors++;
            end
        end
        finish_test("LUI and ADDI");

        for (int k = 0; k < N_RTYPE; k++) begin
            rnd = rand_word();
            f3  = rnd[2:0];
            alt = rnd[3] && (f3 == F3_ADD || f3 == F3_SR);
            issue_instr(enc_r(alt ? 7'h20 : 7'h00, rnd[8:4], rnd[13:9], f3, rnd[18:14]));
        end
        finish_test("R-type");

        for (int k = 0; k < N_ITYPE; k++) begin
            rnd = rand_word();
            f3  = rnd[2:0];
            if (f3 == F3_SLL)
                imm = {7'h00, rnd[24:20]};
            else if (f3 == F3_SR)
                imm = {1'b0, rnd[3], 5'b0, rnd[24:20]};  // SRAI sets bit 30
            else
                imm = rnd[31:20];
            issue_instr(enc_i(imm, rnd[8:4], f3, rnd[18:14]));
        end
        finish_test("I-type");

        // Each instruction reads the register written d instructions before
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < CHAIN_LEN; k++) begin
                rnd = rand_word();
                rd  = reg_addr_t'(20 + k % d);
                rs2 = reg_addr_t'(1 + rnd[7:0] % 9);
                if (k % 2 == 0)
                    issue_instr(enc_i(rnd[31:20], rd, rnd[9] ? F3_XOR : F3_ADD, rd));
                else
                    issue_instr(enc_r(rnd[8] ? 7'h20 : 7'h00, rs2, rd, F3_ADD, rd));
            end
        end
        finish_test("forwarding");

        bad_ops = '{7'h63, 7'h03, 7'h23, 7'h6f, 7'h67, 7'h17};
        for (int k = 0; k < N_NOWB; k++) begin
            rnd = rand_word();
            if (k % 2 == 0)
                ins = {rnd[31:7], bad_ops[(k / 2) % 6]};
            else if (k % 4 == 1)
                ins = {rnd[31:12], 5'd0, OPC_OP};
            else if (k % 3 == 0)
                ins = {rnd[31:12], 5'd0, OPC_LUI};
            else
                ins = {rnd[31:12], 5'd0, OPC_OP_IMM};
            rd = ins[11:7];
            issue_instr(ins);
            issue_instr(enc_i(12'h000, rd, F3_OR, (rd == 5'd31) ? 5'd30 : 5'd31));
        end
        finish_test("no write-back");

        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- int_pipe.f
logic/int_pipe_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/int_pipe.sv
testbench/int_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module int_pipe_tb -f int_pipe.f

sim_out=$(./obj_dir/Vint_pipe_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
else
    exit 1
fi
